/* Bender.yml */
package:
  name: mips_int_pipe

export_include_dirs:
  - .

sources:
  - mips_int_pipe_pkg.sv
  - id_ex_if.sv
  - alu_controller.sv
  - control_unit.sv
  - reg_file.sv
  - decode_stage.sv
  - execute_stage.sv
  - mips_int_pipe.sv
  - target: test
    files:
      - tb_checker.sv
      - tb_mips_int_pipe.sv

/* alu_controller.sv */
`include "mips_int_pipe_macros.svh"

module alu_controller import mips_int_pipe_pkg::*; (
    input  opcode_t opcode,
    input  funct_t  funct,
    output alu_op_t alu_operation
);
    always_comb begin
        alu_operation = `ALU_ADD;
        if (opcode == `OP_RTYPE) begin
            case (funct)
                `FN_SUB, `FN_SUBU:  alu_operation = `ALU_SUB;
                `FN_AND:            alu_operation = `ALU_AND;
                `FN_OR:             alu_operation = `ALU_OR;
                `FN_XOR:            alu_operation = `ALU_XOR;
                `FN_NOR:            alu_operation = `ALU_NOR;
                `FN_SLT:            alu_operation = `ALU_SLT;
                `FN_SLL, `FN_SLLV:  alu_operation = `ALU_SLL;
                `FN_SRL, `FN_SRLV:  alu_operation = `ALU_SRL;
                `FN_SRA:            alu_operation = `ALU_SRA;
                default:            alu_operation = `ALU_ADD;  // add, addu, jr, syscall
            endcase
        end else begin
            case (opcode)
                `OP_ANDI: alu_operation = `ALU_AND;
                `OP_ORI:  alu_operation = `ALU_OR;
                `OP_XORI: alu_operation = `ALU_XOR;
                `OP_SLTI: alu_operation = `ALU_SLT;
                `OP_LUI:  alu_operation = `ALU_LUI;
                // compare by subtraction
                `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_BGEZ:
                    alu_operation = `ALU_SUB;
                default:  alu_operation = `ALU_ADD;
            endcase
        end
    end
endmodule

/* control_unit.sv */
`include "mips_int_pipe_macros.svh"

module control_unit import mips_int_pipe_pkg::*; (
    input  instr_t  instr,
    output logic    reg_dest,
    output logic    alu_src,
    output logic    is_unsigned,
    output logic    reg_write_enable,
    output logic    does_shift_amount_need,
    output opcode_t branch_op,
    output logic    jump,
    output logic    jump_register,
    output logic    link,
    output logic    halted,
    output alu_op_t alu_operation
);
    opcode_t opcode;
    funct_t  funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    alu_controller u_alu_ctrl (
        .opcode       (opcode),
        .funct        (funct),
        .alu_operation(alu_operation)
    );

    always_comb begin
        reg_dest               = 1'b0;
        alu_src                = 1'b0;
        is_unsigned            = 1'b0;
        reg_write_enable       = 1'b0;
        does_shift_amount_need = 1'b0;
        branch_op              = '0;
        jump                   = 1'b0;
        jump_register          = 1'b0;
        link                   = 1'b0;
        halted                 = 1'b0;
        case (opcode)
            `OP_RTYPE:
                case (funct)
                    `FN_SYSCALL: halted = 1'b1;
                    `FN_JR:      jump_register = 1'b1;
                    `FN_SLL, `FN_SRL, `FN_SRA: begin
                        reg_dest               = 1'b1;
                        reg_write_enable       = 1'b1;
                        does_shift_amount_need = 1'b1;
                    end
                    `FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND, `FN_OR,
                    `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLLV, `FN_SRLV: begin
                        reg_dest         = 1'b1;
                        reg_write_enable = 1'b1;
                    end
                    default: ;
                endcase
            `OP_ADDIU, `OP_ANDI, `OP_ORI, `OP_XORI: begin
                reg_write_enable = 1'b1;
                alu_src          = 1'b1;
                is_unsigned      = 1'b1;  // zero-extended immediate
            end
            `OP_ADDI, `OP_SLTI, `OP_LUI: begin
                reg_write_enable = 1'b1;
                alu_src          = 1'b1;
            end
            `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_BGEZ:
                branch_op = opcode;
            `OP_J:   jump = 1'b1;
            `OP_JAL: begin
                jump             = 1'b1;
                link             = 1'b1;
                reg_write_enable = 1'b1;
            end
            default: ;
        endcase
    end
endmodule

/* decode_stage.sv */
`include "mips_int_pipe_macros.svh"

module decode_stage import mips_int_pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  instr_t    instr,
    input  word_t     pc,
    input  logic      instr_valid,
    input  logic      stall,
    input  logic      halted,
    output reg_addr_t rs_addr,
    output reg_addr_t rt_addr,
    input  word_t     rs_val,
    input  word_t     rt_val,
    id_ex_if.producer id_ex
);
    reg_addr_t rd_addr;
    reg_addr_t dest_addr;
    word_t     imm_ext;
    logic      accept;
    logic      reg_dest, alu_src, is_unsigned, reg_write_enable, shift_amount;
    logic      jump, jump_register, link, halt;
    opcode_t   branch_op;
    alu_op_t   alu_op;

    assign rs_addr = instr[25:21];
    assign rt_addr = instr[20:16];
    assign rd_addr = instr[15:11];

    assign accept    = instr_valid && !stall && !halted;
    assign dest_addr = link ? `LINK_REG : (reg_dest ? rd_addr : rt_addr);
    assign imm_ext   = is_unsigned ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    control_unit u_ctrl (
        .instr                 (instr),
        .reg_dest              (reg_dest),
        .alu_src               (alu_src),
        .is_unsigned           (is_unsigned),
        .reg_write_enable      (reg_write_enable),
        .does_shift_amount_need(shift_amount),
        .branch_op             (branch_op),
        .jump                  (jump),
        .jump_register         (jump_register),
        .link                  (link),
        .halted                (halt),
        .alu_operation         (alu_op)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid <= accept;  // bubble otherwise
        end
    end

    // payload only meaningful with valid
    always_ff @(posedge clk) begin
        id_ex.pc               <= pc;
        id_ex.rs_val           <= rs_val;
        id_ex.rt_val           <= rt_val;
        id_ex.imm              <= imm_ext;
        id_ex.shamt            <= instr[10:6];
        id_ex.rs_addr          <= rs_addr;
        id_ex.rt_addr          <= rt_addr;
        id_ex.dest_addr        <= dest_addr;
        id_ex.alu_op           <= alu_op;
        id_ex.alu_src          <= alu_src;
        id_ex.is_unsigned      <= is_unsigned;
        id_ex.shift_amount     <= shift_amount;
        id_ex.reg_write_enable <= reg_write_enable;
        id_ex.link             <= link;
        id_ex.branch_op        <= branch_op;
        id_ex.jump             <= jump;
        id_ex.jump_register    <= jump_register;
        id_ex.halt             <= halt;
    end
endmodule

/* execute_stage.sv */
`include "mips_int_pipe_macros.svh"

module execute_stage import mips_int_pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    id_ex_if.consumer id_ex,
    output logic      wb_en,
    output reg_addr_t wb_addr,
    output word_t     wb_data,
    output logic      redirect,
    output word_t     redirect_pc,
    output logic      halted
);
    word_t      op_a, rt_fwd, op_b, alu_result;
    word_t      branch_target, jump_target, next_pc;
    logic [4:0] shift;
    logic       rs_only, lt, zero, negative, taken, fire;

    // forward from the EX/WB register
    assign op_a   = (wb_en && wb_addr != '0 && wb_addr == id_ex.rs_addr) ? wb_data : id_ex.rs_val;
    assign rt_fwd = (wb_en && wb_addr != '0 && wb_addr == id_ex.rt_addr) ? wb_data : id_ex.rt_val;

    // blez/bgtz/bgez compare rs against zero
    assign rs_only = id_ex.branch_op inside {`OP_BLEZ, `OP_BGTZ, `OP_BGEZ};
    assign op_b    = id_ex.alu_src ? id_ex.imm : (rs_only ? '0 : rt_fwd);
    assign shift   = id_ex.shift_amount ? id_ex.shamt : op_a[4:0];
    assign lt      = id_ex.is_unsigned ? (op_a < op_b) : ($signed(op_a) < $signed(op_b));

    always_comb begin
        case (id_ex.alu_op)
            `ALU_SUB: alu_result = op_a - op_b;
            `ALU_AND: alu_result = op_a & op_b;
            `ALU_OR:  alu_result = op_a | op_b;
            `ALU_XOR: alu_result = op_a ^ op_b;
            `ALU_NOR: alu_result = ~(op_a | op_b);
            `ALU_SLT: alu_result = {{(`XLEN-1){1'b0}}, lt};
            `ALU_SLL: alu_result = op_b << shift;
            `ALU_SRL: alu_result = op_b >> shift;
            `ALU_SRA: alu_result = $signed(op_b) >>> shift;
            `ALU_LUI: alu_result = {op_b[15:0], 16'b0};
            default:  alu_result = op_a + op_b;
        endcase
    end

    assign zero     = (alu_result == '0);
    assign negative = alu_result[`XLEN-1];

    always_comb begin
        case (id_ex.branch_op)
            `OP_BEQ:  taken = zero;
            `OP_BNE:  taken = !zero;
            `OP_BLEZ: taken = negative || zero;
            `OP_BGTZ: taken = !negative && !zero;
            `OP_BGEZ: taken = !negative;
            default:  taken = 1'b0;
        endcase
    end

    assign branch_target = id_ex.pc + 32'd4 + {id_ex.imm[29:0], 2'b00};
    // 26-bit target rebuilt from the rs, rt and imm fields
    assign jump_target = {id_ex.pc[31:28], id_ex.rs_addr, id_ex.rt_addr, id_ex.imm[15:0], 2'b00};
    assign next_pc     = id_ex.jump_register ? op_a : (id_ex.jump ? jump_target : branch_target);
    assign fire        = id_ex.valid && !halted;  // nothing retires once halted

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en    <= 1'b0;
            redirect <= 1'b0;
            halted   <= 1'b0;
        end else begin
            wb_en    <= fire && id_ex.reg_write_enable;
            redirect <= fire && (taken || id_ex.jump || id_ex.jump_register);
            halted   <= halted || (fire && id_ex.halt);  // sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        wb_addr     <= id_ex.dest_addr;
        wb_data     <= id_ex.link ? id_ex.pc + 32'd8 : alu_result;
        redirect_pc <= next_pc;
    end
endmodule

/* id_ex_if.sv */
interface id_ex_if import mips_int_pipe_pkg::*; (
    input logic clk
);
    logic       valid;
    word_t      pc;
    word_t      rs_val;
    word_t      rt_val;
    word_t      imm;            // already extended
    logic [4:0] shamt;
    reg_addr_t  rs_addr;
    reg_addr_t  rt_addr;
    reg_addr_t  dest_addr;
    alu_op_t    alu_op;
    logic       alu_src;
    logic       is_unsigned;
    logic       shift_amount;   // shamt field instead of rs
    logic       reg_write_enable;
    logic       link;
    opcode_t    branch_op;      // zero when not a branch
    logic       jump;
    logic       jump_register;
    logic       halt;

    modport producer (
        input  clk,
        output valid, pc, rs_val, rt_val, imm, shamt, rs_addr, rt_addr, dest_addr,
        output alu_op, alu_src, is_unsigned, shift_amount, reg_write_enable, link,
        output branch_op, jump, jump_register, halt
    );

    modport consumer (
        input clk,
        input valid, pc, rs_val, rt_val, imm, shamt, rs_addr, rt_addr, dest_addr,
        input alu_op, alu_src, is_unsigned, shift_amount, reg_write_enable, link,
        input branch_op, jump, jump_register, halt
    );
endinterface

/* mips_int_pipe.f */
+incdir+.
mips_int_pipe_pkg.sv
id_ex_if.sv
alu_controller.sv
control_unit.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
mips_int_pipe.sv
tb_checker.sv
tb_mips_int_pipe.sv

/* mips_int_pipe.sv */
module mips_int_pipe import mips_int_pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  instr_t    instr,
    input  word_t     pc,
    input  logic      instr_valid,
    input  logic      stall,
    output logic      wb_en,
    output reg_addr_t wb_addr,
    output word_t     wb_data,
    output logic      redirect,
    output word_t     redirect_pc,
    output logic      halted
);
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_val;
    word_t     rt_val;

    id_ex_if u_id_ex (.clk(clk));

    decode_stage u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .pc         (pc),
        .instr_valid(instr_valid),
        .stall      (stall),
        .halted     (halted),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .id_ex      (u_id_ex.producer)
    );

    execute_stage u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_ex      (u_id_ex.consumer),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .halted     (halted)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs_addr(rs_addr),
        .rt_addr(rt_addr),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .wb_en  (wb_en),
        .wb_addr(wb_addr),
        .wb_data(wb_data)
    );
endmodule

/* mips_int_pipe_macros.svh */
`ifndef MIPS_INT_PIPE_MACROS_SVH
`define MIPS_INT_PIPE_MACROS_SVH

`define XLEN     32
`define NREGS    32
`define REG_AW   5
`define OP_W     6
`define ALU_W    5
`define LINK_REG 5'd31  // jal destination

`define OP_RTYPE 6'b000000
`define OP_BGEZ  6'b000001  // regimm with rt = 1
`define OP_J     6'b000010
`define OP_JAL   6'b000011
`define OP_BEQ   6'b000100
`define OP_BNE   6'b000101
`define OP_BLEZ  6'b000110
`define OP_BGTZ  6'b000111
`define OP_ADDI  6'b001000
`define OP_ADDIU 6'b001001
`define OP_SLTI  6'b001010
`define OP_ANDI  6'b001100
`define OP_ORI   6'b001101
`define OP_XORI  6'b001110
`define OP_LUI   6'b001111

`define FN_SLL     6'b000000
`define FN_SRL     6'b000010
`define FN_SRA     6'b000011
`define FN_SLLV    6'b000100
`define FN_SRLV    6'b000110
`define FN_JR      6'b001000
`define FN_SYSCALL 6'b001100
`define FN_ADD     6'b100000
`define FN_ADDU    6'b100001
`define FN_SUB     6'b100010
`define FN_SUBU    6'b100011
`define FN_AND     6'b100100
`define FN_OR      6'b100101
`define FN_XOR     6'b100110
`define FN_NOR     6'b100111
`define FN_SLT     6'b101010

`define ALU_ADD 5'd0
`define ALU_SUB 5'd1
`define ALU_AND 5'd2
`define ALU_OR  5'd3
`define ALU_XOR 5'd4
`define ALU_NOR 5'd5
`define ALU_SLT 5'd6
`define ALU_SLL 5'd7
`define ALU_SRL 5'd8
`define ALU_SRA 5'd9
`define ALU_LUI 5'd10

`endif

/* mips_int_pipe_pkg.sv */
`include "mips_int_pipe_macros.svh"

package mips_int_pipe_pkg;

    typedef logic [`XLEN-1:0]   word_t;      // data word or pc
    typedef logic [`XLEN-1:0]   instr_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;
    typedef logic [`OP_W-1:0]   opcode_t;
    typedef logic [`OP_W-1:0]   funct_t;
    typedef logic [`ALU_W-1:0]  alu_op_t;

endpackage

/* reg_file.sv */
`include "mips_int_pipe_macros.svh"

module reg_file import mips_int_pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    output word_t     rs_val,
    output word_t     rt_val,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data
);
    word_t regs [`NREGS];
    logic  rs_hit;
    logic  rt_hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // write-through on a same-cycle write
    assign rs_hit = wb_en && wb_addr == rs_addr;
    assign rt_hit = wb_en && wb_addr == rt_addr;

    assign rs_val = (rs_addr == '0) ? '0 : (rs_hit ? wb_data : regs[rs_addr]);
    assign rt_val = (rt_addr == '0) ? '0 : (rt_hit ? wb_data : regs[rt_addr]);
endmodule

/* tb_checker.sv */
`include "mips_int_pipe_macros.svh"

module tb_checker import mips_int_pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  instr_t    instr,
    input  logic      instr_valid,
    input  logic      stall,
    input  int        test_idx,
    input  logic      exp_we,
    input  reg_addr_t exp_addr,
    input  word_t     exp_data,
    input  logic      exp_redir,
    input  word_t     exp_rpc,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    input  logic      redirect,
    input  word_t     redirect_pc,
    input  logic      halted,
    output int        n_tests,
    output int        n_fail,
    output int        n_err,
    output int        pending
);
    int        q_idx[$];
    int        q_due[$];    // cycle whose falling edge shows the result
    instr_t    q_instr[$];
    logic      q_we[$];
    reg_addr_t q_addr[$];
    word_t     q_data[$];
    logic      q_redir[$];
    word_t     q_rpc[$];
    int        cyc;
    int        n_push;
    int        n_pop;
    logic      exp_halted;

    assign pending = n_push - n_pop;

    initial begin
        cyc        = 0;
        n_push     = 0;
        n_pop      = 0;
        n_tests    = 0;
        n_fail     = 0;
        n_err      = 0;
        exp_halted = 1'b0;
    end

    task automatic compare_front();
        logic bad;
        bad = 1'b0;
        if (wb_en !== q_we[0]) begin
            $display("[ERROR] %0t test %0d: wb_en %b, expected %b", $time, q_idx[0], wb_en,
                     q_we[0]);
            bad = 1'b1;
        end else if (q_we[0] && (wb_addr !== q_addr[0] || wb_data !== q_data[0])) begin
            $display("[ERROR] %0t test %0d: wrote r%0d = %h, expected r%0d = %h", $time,
                     q_idx[0], wb_addr, wb_data, q_addr[0], q_data[0]);
            bad = 1'b1;
        end
        if (redirect !== q_redir[0]) begin
            $display("[ERROR] %0t test %0d: redirect %b, expected %b", $time, q_idx[0],
                     redirect, q_redir[0]);
            bad = 1'b1;
        end else if (q_redir[0] && redirect_pc !== q_rpc[0]) begin
            $display("[ERROR] %0t test %0d: redirect_pc %h, expected %h", $time, q_idx[0],
                     redirect_pc, q_rpc[0]);
            bad = 1'b1;
        end
        // syscall sets halt at its own execute edge
        if (q_instr[0][31:26] == `OP_RTYPE && q_instr[0][5:0] == `FN_SYSCALL) begin
            exp_halted = 1'b1;
        end
        n_tests++;
        if (bad) begin
            n_fail++;
            n_err++;
        end
        $display("test %0d instr %h: %s", q_idx[0], q_instr[0], bad ? "FAIL" : "ok");
        void'(q_idx.pop_front());
        void'(q_due.pop_front());
        void'(q_instr.pop_front());
        void'(q_we.pop_front());
        void'(q_addr.pop_front());
        void'(q_data.pop_front());
        void'(q_redir.pop_front());
        void'(q_rpc.pop_front());
        n_pop++;
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            cyc = cyc + 1;
            if (instr_valid && !stall) begin  // also queued while halted and expected silent
                q_idx.push_back(test_idx);
                q_due.push_back(cyc + 1);
                q_instr.push_back(instr);
                q_we.push_back(exp_we);
                q_addr.push_back(exp_addr);
                q_data.push_back(exp_data);
                q_redir.push_back(exp_redir);
                q_rpc.push_back(exp_rpc);
                n_push++;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (q_due.size() > 0 && q_due[0] == cyc) begin
                compare_front();
            end else if (wb_en !== 1'b0 || redirect !== 1'b0) begin
                $display("[ERROR] %0t: output with no instruction due (wb_en %b, redirect %b)",
                         $time, wb_en, redirect);
                n_err++;
            end
            if (halted !== exp_halted) begin
                $display("[ERROR] %0t: halted %b, expected %b", $time, halted, exp_halted);
                n_err++;
            end
        end
    end
endmodule

/* tb_mips_int_pipe.sv */
`include "mips_int_pipe_macros.svh"

module tb_mips_int_pipe import mips_int_pipe_pkg::*; ();
    localparam int     MAX_ENTRIES  = 64;
    localparam instr_t SYSCALL_WORD = {`OP_RTYPE, 20'd0, `FN_SYSCALL};

    logic      clk;
    logic      rst_n;
    instr_t    instr;
    word_t     pc;
    logic      instr_valid;
    logic      stall;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      redirect;
    word_t     redirect_pc;
    logic      halted;

    int        test_idx;
    logic      exp_we;
    reg_addr_t exp_addr;
    word_t     exp_data;
    logic      exp_redir;
    word_t     exp_rpc;
    int        n_tests;
    int        n_fail;
    int        n_err;
    int        pending;

    instr_t    t_instr[MAX_ENTRIES];
    word_t     t_pc[MAX_ENTRIES];
    logic      t_we[MAX_ENTRIES];
    reg_addr_t t_addr[MAX_ENTRIES];
    word_t     t_data[MAX_ENTRIES];
    logic      t_redir[MAX_ENTRIES];
    word_t     t_rpc[MAX_ENTRIES];
    logic      t_rnd[MAX_ENTRIES];   // random stalls allowed before this entry
    int        n_entries;
    word_t     next_pc;
    int        seed;
    int        hold;
    int        waited;
    int        i;
    logic      timed_out;

    mips_int_pipe dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .pc         (pc),
        .instr_valid(instr_valid),
        .stall      (stall),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .halted     (halted)
    );

    tb_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .instr_valid(instr_valid),
        .stall      (stall),
        .test_idx   (test_idx),
        .exp_we     (exp_we),
        .exp_addr   (exp_addr),
        .exp_data   (exp_data),
        .exp_redir  (exp_redir),
        .exp_rpc    (exp_rpc),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .halted     (halted),
        .n_tests    (n_tests),
        .n_fail     (n_fail),
        .n_err      (n_err),
        .pending    (pending)
    );

    always #2 clk = ~clk;

    function automatic instr_t r_type(input int rs, input int rt, input int rd, input int sh,
                                      input logic [5:0] fn);
        return {`OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic instr_t i_type(input logic [5:0] op, input int rs, input int rt,
                                      input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic instr_t j_type(input logic [5:0] op, input int target);
        return {op, target[25:0]};
    endfunction

    task automatic add_entry(input instr_t ins, input int we, input int addr, input word_t data,
                             input int redir, input word_t rpc, input int rnd);
        t_instr[n_entries] = ins;
        t_pc[n_entries]    = next_pc;
        t_we[n_entries]    = (we != 0);
        t_addr[n_entries]  = addr[4:0];
        t_data[n_entries]  = data;
        t_redir[n_entries] = (redir != 0);
        t_rpc[n_entries]   = rpc;
        t_rnd[n_entries]   = (rnd != 0);
        n_entries++;
        next_pc = next_pc + 32'd4;
    endtask

    // expected values worked out by hand with register state carried along
    task automatic build_table();
        n_entries = 0;
        next_pc   = 32'h0000_0100;
        add_entry(i_type(`OP_ADDI, 0, 1, 5), 1, 1, 32'h0000_0005, 0, 0, 0);
        add_entry(i_type(`OP_ADDI, 0, 2, -3), 1, 2, 32'hFFFF_FFFD, 0, 0, 0);
        add_entry(i_type(`OP_ORI, 0, 3, 'h8001), 1, 3, 32'h0000_8001, 0, 0, 0);
        add_entry(i_type(`OP_LUI, 0, 4, 'h1234), 1, 4, 32'h1234_0000, 0, 0, 0);
        add_entry(r_type(1, 2, 5, 0, `FN_ADD), 1, 5, 32'h0000_0002, 0, 0, 0);
        add_entry(r_type(1, 2, 6, 0, `FN_SUB), 1, 6, 32'h0000_0008, 0, 0, 0);
        add_entry(r_type(3, 2, 7, 0, `FN_AND), 1, 7, 32'h0000_8001, 0, 0, 0);
        add_entry(r_type(1, 0, 8, 0, `FN_NOR), 1, 8, 32'hFFFF_FFFA, 0, 0, 0);
        add_entry(r_type(2, 1, 9, 0, `FN_SLT), 1, 9, 32'h0000_0001, 0, 0, 0);
        add_entry(i_type(`OP_SLTI, 2, 10, -2), 1, 10, 32'h0000_0001, 0, 0, 0);
        add_entry(i_type(`OP_ANDI, 2, 11, 'hFFF0), 1, 11, 32'h0000_FFF0, 0, 0, 0);  // zero-ext
        add_entry(r_type(0, 1, 12, 4, `FN_SLL), 1, 12, 32'h0000_0050, 0, 0, 0);
        add_entry(r_type(0, 2, 13, 28, `FN_SRL), 1, 13, 32'h0000_000F, 0, 0, 0);
        add_entry(r_type(0, 2, 14, 1, `FN_SRA), 1, 14, 32'hFFFF_FFFE, 0, 0, 0);
        add_entry(r_type(1, 3, 15, 0, `FN_SLLV), 1, 15, 32'h0010_0020, 0, 0, 0);
        add_entry(r_type(1, 4, 16, 0, `FN_SRLV), 1, 16, 32'h0091_A000, 0, 0, 0);
        // back-to-back chain
        add_entry(i_type(`OP_ADDI, 0, 17, 1), 1, 17, 32'h0000_0001, 0, 0, 0);
        add_entry(r_type(17, 17, 17, 0, `FN_ADD), 1, 17, 32'h0000_0002, 0, 0, 0);
        add_entry(r_type(17, 17, 18, 0, `FN_ADD), 1, 18, 32'h0000_0004, 0, 0, 0);
        add_entry(r_type(18, 17, 19, 0, `FN_SUB), 1, 19, 32'h0000_0002, 0, 0, 0);
        add_entry(i_type(`OP_ADDI, 18, 0, 7), 1, 0, 32'h0000_000B, 0, 0, 0);
        add_entry(r_type(0, 18, 20, 0, `FN_ADD), 1, 20, 32'h0000_0004, 0, 0, 0);
        // same kind of chain with random stalls
        add_entry(i_type(`OP_ADDI, 20, 21, 3), 1, 21, 32'h0000_0007, 0, 0, 1);
        add_entry(r_type(21, 20, 22, 0, `FN_XOR), 1, 22, 32'h0000_0003, 0, 0, 1);
        add_entry(r_type(22, 21, 23, 0, `FN_OR), 1, 23, 32'h0000_0007, 0, 0, 1);
        add_entry(r_type(23, 22, 24, 0, `FN_SUBU), 1, 24, 32'h0000_0004, 0, 0, 1);
        add_entry(i_type(`OP_ADDIU, 24, 25, 'h10), 1, 25, 32'h0000_0014, 0, 0, 1);
        add_entry(r_type(25, 24, 26, 0, `FN_ADDU), 1, 26, 32'h0000_0018, 0, 0, 1);
        // taken and not-taken branches starting at pc 0x170
        add_entry(i_type(`OP_BEQ, 1, 1, 4), 0, 0, 0, 1, 32'h0000_0184, 0);
        add_entry(i_type(`OP_BEQ, 1, 2, 4), 0, 0, 0, 0, 0, 0);
        add_entry(i_type(`OP_BNE, 1, 2, -2), 0, 0, 0, 1, 32'h0000_0174, 0);
        add_entry(i_type(`OP_BNE, 1, 1, 4), 0, 0, 0, 0, 0, 0);
        add_entry(i_type(`OP_BLEZ, 2, 0, 8), 0, 0, 0, 1, 32'h0000_01A4, 0);
        add_entry(i_type(`OP_BLEZ, 0, 0, 1), 0, 0, 0, 1, 32'h0000_018C, 0);
        add_entry(i_type(`OP_BLEZ, 1, 0, 4), 0, 0, 0, 0, 0, 0);
        add_entry(i_type(`OP_BGTZ, 1, 0, 2), 0, 0, 0, 1, 32'h0000_0198, 0);
        add_entry(i_type(`OP_BGTZ, 0, 0, 4), 0, 0, 0, 0, 0, 0);
        add_entry(i_type(`OP_BGEZ, 0, 1, 3), 0, 0, 0, 1, 32'h0000_01A4, 0);
        add_entry(i_type(`OP_BGEZ, 2, 1, 4), 0, 0, 0, 0, 0, 0);
        next_pc = 32'h9000_0010;  // upper pc bits show in the jump target
        add_entry(j_type(`OP_J, 'h80), 0, 0, 0, 1, 32'h9000_0200, 0);
        add_entry(r_type(4, 0, 0, 0, `FN_JR), 0, 0, 0, 1, 32'h1234_0000, 0);
        add_entry(j_type(`OP_JAL, 'h100), 1, 31, 32'h9000_0020, 1, 32'h9000_0400, 0);
        add_entry(r_type(31, 0, 27, 0, `FN_ADD), 1, 27, 32'h9000_0020, 0, 0, 0);
        add_entry(SYSCALL_WORD, 0, 0, 0, 0, 0, 0);
        // after halt nothing retires
        add_entry(i_type(`OP_ADDI, 0, 1, 9), 0, 0, 0, 0, 0, 0);
        add_entry(j_type(`OP_J, 'h80), 0, 0, 0, 0, 0, 0);
    endtask

    task automatic apply_entry(input int idx, input logic hold_it);
        instr       = t_instr[idx];
        pc          = t_pc[idx];
        instr_valid = 1'b1;
        stall       = hold_it;
        test_idx    = idx;
        exp_we      = t_we[idx];
        exp_addr    = t_addr[idx];
        exp_data    = t_data[idx];
        exp_redir   = t_redir[idx];
        exp_rpc     = t_rpc[idx];
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr       = '0;
        pc          = '0;
        instr_valid = 1'b0;
        stall       = 1'b0;
        test_idx    = 0;
        exp_we      = 1'b0;
        exp_addr    = '0;
        exp_data    = '0;
        exp_redir   = 1'b0;
        exp_rpc     = '0;
        timed_out   = 1'b0;
        seed        = 13037;
        hold        = $urandom(seed);
        build_table();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        for (i = 0; i < n_entries; i++) begin
            if (t_rnd[i]) begin
                hold = $urandom % 3;
                repeat (hold) begin
                    apply_entry(i, 1'b1);  // held and not accepted
                    @(negedge clk);
                end
            end
            apply_entry(i, 1'b0);
            @(negedge clk);
            if (t_instr[i] == SYSCALL_WORD) begin
                instr_valid = 1'b0;
                waited      = 0;
                while (!halted && waited < 10) begin
                    @(negedge clk);
                    waited++;
                end
                if (!halted) begin
                    $display("timeout: halted never rose after the syscall");
                    timed_out = 1'b1;
                end
            end
        end
        instr_valid = 1'b0;

        waited = 0;
        while (pending != 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("timeout: %0d results never appeared", pending);
            timed_out = 1'b1;
        end
        repeat (3) @(negedge clk);  // idle cycles must show no stray outputs

        $display("tests run %0d, failed %0d, error lines %0d", n_tests, n_fail, n_err);
        if (!timed_out && n_err == 0 && n_tests == n_entries) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end
endmodule
